//--- apb_subsys_top.f
verilog/apb_pkg.sv
verilog/skid_fifo.sv
verilog/apb_master.sv
verilog/apb_decoder.sv
verilog/apb_reg_bank.sv
verilog/apb_wait_ram.sv
verilog/apb_subsys_top.sv
test/tb_apb_subsys.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the APB subsystem testbench with Verilator
cd "$(dirname "$0")" &&
rm -f build.log sim.log &&
verilator --binary --assert --timing --top-module tb_apb_subsys \
    -f apb_subsys_top.f -o tb_apb_subsys > build.log 2>&1 &&
{ ./obj_dir/tb_apb_subsys > sim.log 2>&1; true; } &&
! grep -q "STATUS: FAIL" sim.log &&
grep -q "STATUS: PASS" sim.log &&
echo "Simulation passed" ||
{ echo "Simulation failed, see build.log and sim.log"; exit 1; }

//--- test/tb_apb_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module tb_apb_subsys
    import apb_pkg::*;
();

    localparam int CMD_DEPTH   = 4;
    localparam int RSP_DEPTH   = 4;
    localparam int RAM_WORDS   = 64;
    localparam int WAIT_CYCLES = 2;
    localparam int NUM_REGS    = 16;

    localparam int N_REG   = 32;
    localparam int N_RAM   = 32;
    localparam int N_UNMAP = 8;
    localparam int N_PRIV  = 4;
    localparam int N_MIX   = 64;
    localparam int N_CMDS  = RAM_WORDS + N_REG + N_RAM + N_UNMAP + 2 * N_PRIV + N_MIX;
    localparam int TIMEOUT = N_CMDS * (WAIT_CYCLES + 8) + 200;

    logic     aclk;
    logic     aresetn;
    logic     i_cmd_valid;
    logic     o_cmd_ready;
    apb_cmd_t i_cmd;
    logic     o_rsp_valid;
    logic     i_rsp_ready = 1'b1;
    apb_rsp_t o_rsp;
    logic     w_rsp_fire;

    // Reference model of both targets
    logic [DATA_W-1:0] reg_model [NUM_REGS];
    logic [DATA_W-1:0] ram_model [RAM_WORDS];

    // Expected responses, indexed in command order
    logic [DATA_W-1:0] exp_rdata [N_CMDS+1];
    logic              exp_chk   [N_CMDS+1];
    logic              exp_err   [N_CMDS+1];
    logic              exp_first [N_CMDS+1];
    logic              exp_last  [N_CMDS+1];

    int          n_issued     = 0;
    int          rsp_idx;
    int          val_errs     = 0;
    int          other_errs   = 0;
    int          cycle_cnt    = 0;
    int          stall_cycles = 0;
    logic [15:0] cmd_lfsr     = 16'd12707;
    logic [15:0] bp_lfsr      = 16'd12707;
    logic        bp_mode      = 1'b0;
    logic        ready_bit;

    initial aclk = 1'b0;
    always #2 aclk = ~aclk;

    apb_subsys_top #(
        .CMD_DEPTH   (CMD_DEPTH),
        .RSP_DEPTH   (RSP_DEPTH),
        .RAM_WORDS   (RAM_WORDS),
        .WAIT_CYCLES (WAIT_CYCLES)
    ) i_dut (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .i_cmd_valid (i_cmd_valid),
        .o_cmd_ready (o_cmd_ready),
        .i_cmd       (i_cmd),
        .o_rsp_valid (o_rsp_valid),
        .i_rsp_ready (i_rsp_ready),
        .o_rsp       (o_rsp)
    );

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            cmd_lfsr = lfsr_next(cmd_lfsr);
            v = {v[30:0], cmd_lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old,
                                                      input logic [DATA_W-1:0] data,
                                                      input logic [STRB_W-1:0] strb);
        logic [DATA_W-1:0] res;
        res = old;
        for (int b = 0; b < STRB_W; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = data[8*b +: 8];
            end
        end
        return res;
    endfunction

    function automatic logic [ADDR_W-1:0] reg_addr();
        return REG_BASE + ADDR_W'({take_bits(4), 2'b00});
    endfunction

    function automatic logic [ADDR_W-1:0] ram_addr();
        return RAM_BASE + ADDR_W'({take_bits($clog2(RAM_WORDS)), 2'b00});
    endfunction

    // 0x4000 to 0x7FFF, or 0xC000 to 0xFFFF
    function automatic logic [ADDR_W-1:0] unmapped_addr();
        logic [ADDR_W-1:0] a;
        a = 16'h4000 | ADDR_W'(take_bits(14));
        if (take_bits(1) != 32'd0) begin
            a = a | 16'h8000;
        end
        return a;
    endfunction

    function automatic apb_cmd_t make_cmd(input logic [ADDR_W-1:0] addr, input logic write,
                                          input logic [2:0] prot);
        apb_cmd_t c;
        c.addr  = addr;
        c.write = write;
        c.prot  = prot;
        c.wdata = DATA_W'(take_bits(DATA_W));
        c.strb  = STRB_W'(take_bits(STRB_W));
        c.first = 1'(take_bits(1));
        c.last  = 1'(take_bits(1));
        return c;
    endfunction

    // Predict the response, update the model, then hand the command over
    task automatic issue_cmd(input apb_cmd_t cmd);
        int idx;
        exp_first[n_issued] = cmd.first;
        exp_last[n_issued]  = cmd.last;
        exp_chk[n_issued]   = !cmd.write;
        exp_err[n_issued]   = 1'b0;
        exp_rdata[n_issued] = '0;
        if ((cmd.addr - REG_BASE) < REG_SPAN) begin
            idx = int'((cmd.addr - REG_BASE) >> 2);
            if (cmd.write && cmd.prot[0]) begin
                reg_model[idx] = merge_bytes(reg_model[idx], cmd.wdata, cmd.strb);
            end else if (cmd.write) begin
                exp_err[n_issued] = 1'b1;
            end else begin
                exp_rdata[n_issued] = reg_model[idx];
            end
        end else if ((cmd.addr - RAM_BASE) < ADDR_W'(RAM_WORDS * 4)) begin
            idx = int'((cmd.addr - RAM_BASE) >> 2);
            if (cmd.write) begin
                ram_model[idx] = merge_bytes(ram_model[idx], cmd.wdata, cmd.strb);
            end else begin
                exp_rdata[n_issued] = ram_model[idx];
            end
        end else begin
            exp_chk[n_issued] = 1'b1;
            exp_err[n_issued] = 1'b1;
        end
        n_issued++;

        i_cmd       = cmd;
        i_cmd_valid = 1'b1;
        while (!o_cmd_ready) begin
            stall_cycles++;
            @(negedge aclk);
        end
        @(negedge aclk);
    endtask

    // One ready in four cycles while back-pressure is on
    always @(negedge aclk) begin
        if (bp_mode) begin
            bp_lfsr     = lfsr_next(bp_lfsr);
            ready_bit   = bp_lfsr[0];
            bp_lfsr     = lfsr_next(bp_lfsr);
            i_rsp_ready = ready_bit & bp_lfsr[0];
        end else begin
            i_rsp_ready = 1'b1;
        end
    end

    assign w_rsp_fire = o_rsp_valid && i_rsp_ready;

    always @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            rsp_idx <= 0;
        end else if (w_rsp_fire) begin
            rsp_idx <= rsp_idx + 1;
        end
    end

    always @(posedge aclk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT) begin
            $display("Timeout after %0d cycles, responses missing: got %0d of %0d",
                     cycle_cnt, rsp_idx, n_issued);
            $display("Errors: %0d wrong values, %0d other", val_errs, other_errs + 1);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    a_rsp_known: assert property (@(posedge aclk) disable iff (!aresetn)
        w_rsp_fire |-> (rsp_idx < n_issued))
        else begin
            other_errs++;
            $display("A response arrived with no command left to answer it");
        end

    a_rsp_err: assert property (@(posedge aclk) disable iff (!aresetn)
        w_rsp_fire && (rsp_idx < n_issued) |-> (o_rsp.slverr == exp_err[rsp_idx]))
        else begin
            val_errs++;
            $display("ERR %0t: response %0d slverr %0b, expected %0b", $time,
                     $sampled(rsp_idx), $sampled(o_rsp.slverr), exp_err[$sampled(rsp_idx)]);
        end

    a_rsp_data: assert property (@(posedge aclk) disable iff (!aresetn)
        w_rsp_fire && (rsp_idx < n_issued) |->
            (!exp_chk[rsp_idx] || (o_rsp.rdata == exp_rdata[rsp_idx])))
        else begin
            val_errs++;
            $display("ERR %0t: response %0d rdata %h, expected %h", $time,
                     $sampled(rsp_idx), $sampled(o_rsp.rdata), exp_rdata[$sampled(rsp_idx)]);
        end

    a_rsp_marks: assert property (@(posedge aclk) disable iff (!aresetn)
        w_rsp_fire && (rsp_idx < n_issued) |->
            ({o_rsp.first, o_rsp.last} == {exp_first[rsp_idx], exp_last[rsp_idx]}))
        else begin
            val_errs++;
            $display("ERR %0t: response %0d first/last markers out of order", $time,
                     $sampled(rsp_idx));
        end

    initial begin
        apb_cmd_t    c;
        logic [1:0]  kind;
        logic        wr;
        logic [15:0] a;
        aresetn     = 1'b0;
        i_cmd_valid = 1'b0;
        i_cmd       = '0;
        for (int i = 0; i < NUM_REGS; i++) begin
            reg_model[i] = '0;
        end
        repeat (16) @(posedge aclk);
        @(negedge aclk);
        aresetn = 1'b1;
        @(negedge aclk);

        // Fill every RAM word so later reads are defined
        for (int i = 0; i < RAM_WORDS; i++) begin
            c      = make_cmd(RAM_BASE + ADDR_W'(i * 4), 1'b1, 3'b001);
            c.strb = '1;
            issue_cmd(c);
        end
        for (int i = 0; i < N_REG; i++) begin
            issue_cmd(make_cmd(reg_addr(), 1'(take_bits(1)), 3'b001));
        end
        for (int i = 0; i < N_RAM; i++) begin
            issue_cmd(make_cmd(ram_addr(), 1'(take_bits(1)), 3'(take_bits(3))));
        end
        for (int i = 0; i < N_UNMAP; i++) begin
            issue_cmd(make_cmd(unmapped_addr(), 1'(take_bits(1)), 3'(take_bits(3))));
        end
        for (int i = 0; i < N_PRIV; i++) begin
            a = reg_addr();
            issue_cmd(make_cmd(a, 1'b1, 3'b000));
            issue_cmd(make_cmd(a, 1'b0, 3'b001));
        end

        // Mixed traffic with random gaps and response back-pressure
        bp_mode = 1'b1;
        for (int i = 0; i < N_MIX; i++) begin
            kind = 2'(take_bits(2));
            wr   = 1'(take_bits(1));
            case (kind)
                2'd0:    c = make_cmd(reg_addr(), wr, 3'b001);
                2'd1:    c = make_cmd(ram_addr(), wr, 3'(take_bits(3)));
                2'd2:    c = make_cmd(unmapped_addr(), wr, 3'(take_bits(3)));
                default: c = make_cmd(reg_addr(), wr, 3'(take_bits(3)));
            endcase
            issue_cmd(c);
            if (take_bits(2) == 32'd0) begin
                i_cmd_valid = 1'b0;
                @(negedge aclk);
            end
        end
        i_cmd_valid = 1'b0;

        while (rsp_idx != n_issued) begin
            @(negedge aclk);
        end
        repeat (8) @(negedge aclk);

        if (stall_cycles == 0) begin
            other_errs++;
            $display("The command FIFO never filled, so o_cmd_ready never fell");
        end
        if (rsp_idx != N_CMDS) begin
            other_errs++;
            $display("Got %0d responses for %0d commands", rsp_idx, N_CMDS);
        end
        $display("Errors: %0d wrong values, %0d other", val_errs, other_errs);
        if (val_errs + other_errs == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/apb_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module apb_decoder
    import apb_pkg::*;
#(
    parameter int RAM_WORDS = 64
) (
    input  wire apb_req_t i_req,
    input  wire apb_ret_t i_reg_ret,
    input  wire apb_ret_t i_ram_ret,
    output logic          o_reg_sel,
    output logic          o_ram_sel,
    output apb_ret_t      o_ret
);

    // One extra bit so a RAM filling the upper half still fits
    localparam logic [ADDR_W:0] RAM_SPAN = (ADDR_W + 1)'(RAM_WORDS * 4);

    logic [ADDR_W-1:0] w_reg_off;
    logic [ADDR_W-1:0] w_ram_off;
    logic              w_reg_hit;
    logic              w_ram_hit;

    always_comb begin
        w_reg_off = i_req.paddr - REG_BASE;
        w_ram_off = i_req.paddr - RAM_BASE;
        w_reg_hit = (w_reg_off < REG_SPAN);
        w_ram_hit = ({1'b0, w_ram_off} < RAM_SPAN);

        o_reg_sel = i_req.psel && w_reg_hit;
        o_ram_sel = i_req.psel && w_ram_hit;

        if (w_reg_hit) begin
            o_ret = i_reg_ret;
        end else if (w_ram_hit) begin
            o_ret = i_ram_ret;
        end else begin
            // Unmapped, finish at once with an error
            o_ret.prdata  = '0;
            o_ret.pready  = 1'b1;
            o_ret.pslverr = 1'b1;
        end

        // Windows must not overlap for this RAM size
        a_one_sel: assert (!(o_reg_sel && o_ram_sel))
            else $error("register and RAM windows both selected");
    end

endmodule

`default_nettype wire

//--- verilog/apb_master.sv
`timescale 1ns/1ps
`default_nettype none

module apb_master
    import apb_pkg::*;
#(
    parameter int CMD_DEPTH = 4,
    parameter int RSP_DEPTH = 4
) (
    input  wire logic     aclk,
    input  wire logic     aresetn,
    input  wire logic     i_cmd_valid,
    output logic          o_cmd_ready,
    input  wire apb_cmd_t i_cmd,
    output logic          o_rsp_valid,
    input  wire logic     i_rsp_ready,
    output apb_rsp_t      o_rsp,
    output apb_req_t      o_req,
    input  wire apb_ret_t i_ret
);

    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        SETUP  = 2'd1,
        ACCESS = 2'd2
    } state_t;

    state_t   r_state;
    state_t   w_next_state;
    apb_cmd_t w_cmd;
    logic     w_cmd_valid;
    logic     w_cmd_pop;
    apb_rsp_t w_rsp;
    logic     w_rsp_push;
    logic     w_rsp_room;

    skid_fifo #(
        .payload_t (apb_cmd_t),
        .DEPTH     (CMD_DEPTH)
    ) u_cmd_fifo (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .i_wr_valid (i_cmd_valid),
        .o_wr_ready (o_cmd_ready),
        .i_wr_data  (i_cmd),
        .o_rd_valid (w_cmd_valid),
        .i_rd_ready (w_cmd_pop),
        .o_rd_data  (w_cmd)
    );

    // Markers of the head command ride along with the target's return
    assign w_rsp = '{last:   w_cmd.last,
                     first:  w_cmd.first,
                     slverr: i_ret.pslverr,
                     rdata:  i_ret.prdata};

    skid_fifo #(
        .payload_t (apb_rsp_t),
        .DEPTH     (RSP_DEPTH)
    ) u_rsp_fifo (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .i_wr_valid (w_rsp_push),
        .o_wr_ready (w_rsp_room),
        .i_wr_data  (w_rsp),
        .o_rd_valid (o_rsp_valid),
        .i_rd_ready (i_rsp_ready),
        .o_rd_data  (o_rsp)
    );

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            r_state <= IDLE;
        end else begin
            r_state <= w_next_state;
        end
    end

    always_comb begin
        o_req.psel    = 1'b0;
        o_req.penable = 1'b0;
        o_req.paddr   = w_cmd.addr;
        o_req.pwrite  = w_cmd.write;
        o_req.pwdata  = w_cmd.write ? w_cmd.wdata : '0;
        o_req.pstrb   = w_cmd.strb;
        o_req.pprot   = w_cmd.prot;
        w_next_state  = r_state;
        w_cmd_pop     = 1'b0;
        w_rsp_push    = 1'b0;

        case (r_state)
            IDLE: begin
                // A valid head entry opens SETUP in the same cycle
                if (w_cmd_valid) begin
                    o_req.psel   = 1'b1;
                    w_next_state = w_rsp_room ? ACCESS : SETUP;
                end
            end
            SETUP: begin
                o_req.psel = 1'b1;
                if (w_rsp_room) begin
                    w_next_state = ACCESS;
                end
            end
            ACCESS: begin
                o_req.psel    = 1'b1;
                o_req.penable = 1'b1;
                if (i_ret.pready) begin
                    w_rsp_push   = 1'b1;
                    w_cmd_pop    = 1'b1;
                    w_next_state = IDLE;
                end
            end
            default: w_next_state = IDLE;
        endcase
    end

    // Request fields hold from SETUP until the transfer completes
    a_req_stable: assert property (@(posedge aclk) disable iff (!aresetn)
        o_req.psel && !(o_req.penable && i_ret.pready) |=>
            o_req.psel && $stable({o_req.paddr, o_req.pwrite, o_req.pwdata,
                                   o_req.pstrb, o_req.pprot}));

endmodule

`default_nettype wire

//--- verilog/apb_pkg.sv
`default_nettype none

package apb_pkg;

    // Bus widths
    localparam int ADDR_W = 16;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    // Address map
    localparam logic [ADDR_W-1:0] REG_BASE = 16'h0000;
    localparam logic [ADDR_W-1:0] REG_SPAN = 16'h0040;
    localparam logic [ADDR_W-1:0] RAM_BASE = 16'h8000;

    // One APB transfer, MSB first
    typedef struct packed {
        logic              last;
        logic              first;
        logic              write;
        logic [2:0]        prot;
        logic [STRB_W-1:0] strb;
        logic [DATA_W-1:0] wdata;
        logic [ADDR_W-1:0] addr;
    } apb_cmd_t;

    typedef struct packed {
        logic              last;
        logic              first;
        logic              slverr;
        logic [DATA_W-1:0] rdata;
    } apb_rsp_t;

    typedef struct packed {
        logic              psel;
        logic              penable;
        logic [ADDR_W-1:0] paddr;
        logic              pwrite;
        logic [DATA_W-1:0] pwdata;
        logic [STRB_W-1:0] pstrb;
        logic [2:0]        pprot;
    } apb_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] prdata;
        logic              pready;
        logic              pslverr;
    } apb_ret_t;

endpackage

`default_nettype wire

//--- verilog/apb_reg_bank.sv
`timescale 1ns/1ps
`default_nettype none

module apb_reg_bank
    import apb_pkg::*;
(
    input  wire logic     aclk,
    input  wire logic     aresetn,
    input  wire logic     i_sel,
    input  wire apb_req_t i_req,
    output apb_ret_t      o_ret
);

    localparam int NUM_REGS = 16;

    logic [DATA_W-1:0] r_regs [NUM_REGS];
    logic [3:0]        w_idx;
    logic              w_access;
    logic              w_wr_ok;
    logic              w_wr_deny;

    assign w_idx    = i_req.paddr[5:2];
    assign w_access = i_sel && i_req.penable;

    // pprot[0] marks a privileged access
    assign w_wr_ok   = w_access && i_req.pwrite && i_req.pprot[0];
    assign w_wr_deny = w_access && i_req.pwrite && !i_req.pprot[0];

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                r_regs[i] <= '0;
            end
        end else if (w_wr_ok) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (i_req.pstrb[b]) begin
                    r_regs[w_idx][8*b +: 8] <= i_req.pwdata[8*b +: 8];
                end
            end
        end
    end

    // Zero wait, so every access completes in its first ACCESS cycle
    always_comb begin
        o_ret.prdata  = r_regs[w_idx];
        o_ret.pready  = 1'b1;
        o_ret.pslverr = w_wr_deny;
    end

endmodule

`default_nettype wire

//--- verilog/apb_subsys_top.sv
`timescale 1ns/1ps
`default_nettype none

module apb_subsys_top
    import apb_pkg::*;
#(
    parameter int CMD_DEPTH   = 4,
    parameter int RSP_DEPTH   = 4,
    parameter int RAM_WORDS   = 64,
    parameter int WAIT_CYCLES = 2
) (
    input  wire logic     aclk,
    input  wire logic     aresetn,
    input  wire logic     i_cmd_valid,
    output logic          o_cmd_ready,
    input  wire apb_cmd_t i_cmd,
    output logic          o_rsp_valid,
    input  wire logic     i_rsp_ready,
    output apb_rsp_t      o_rsp
);

    apb_req_t w_req;
    apb_ret_t w_ret;
    apb_ret_t w_reg_ret;
    apb_ret_t w_ram_ret;
    logic     w_reg_sel;
    logic     w_ram_sel;

    apb_master #(
        .CMD_DEPTH (CMD_DEPTH),
        .RSP_DEPTH (RSP_DEPTH)
    ) u_master (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .i_cmd_valid (i_cmd_valid),
        .o_cmd_ready (o_cmd_ready),
        .i_cmd       (i_cmd),
        .o_rsp_valid (o_rsp_valid),
        .i_rsp_ready (i_rsp_ready),
        .o_rsp       (o_rsp),
        .o_req       (w_req),
        .i_ret       (w_ret)
    );

    apb_decoder #(
        .RAM_WORDS (RAM_WORDS)
    ) u_decoder (
        .i_req     (w_req),
        .i_reg_ret (w_reg_ret),
        .i_ram_ret (w_ram_ret),
        .o_reg_sel (w_reg_sel),
        .o_ram_sel (w_ram_sel),
        .o_ret     (w_ret)
    );

    apb_reg_bank u_reg_bank (
        .aclk    (aclk),
        .aresetn (aresetn),
        .i_sel   (w_reg_sel),
        .i_req   (w_req),
        .o_ret   (w_reg_ret)
    );

    apb_wait_ram #(
        .RAM_WORDS   (RAM_WORDS),
        .WAIT_CYCLES (WAIT_CYCLES)
    ) u_wait_ram (
        .aclk    (aclk),
        .aresetn (aresetn),
        .i_sel   (w_ram_sel),
        .i_req   (w_req),
        .o_ret   (w_ram_ret)
    );

endmodule

`default_nettype wire

//--- verilog/apb_wait_ram.sv
`timescale 1ns/1ps
`default_nettype none

module apb_wait_ram
    import apb_pkg::*;
#(
    parameter int RAM_WORDS   = 64,
    parameter int WAIT_CYCLES = 2
) (
    input  wire logic     aclk,
    input  wire logic     aresetn,
    input  wire logic     i_sel,
    input  wire apb_req_t i_req,
    output apb_ret_t      o_ret
);

    localparam int IDX_W = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;
    localparam int CNT_W = (WAIT_CYCLES > 0) ? $clog2(WAIT_CYCLES + 1) : 1;

    logic [DATA_W-1:0] r_mem [RAM_WORDS];
    logic [CNT_W-1:0]  r_wait_cnt;
    logic [IDX_W-1:0]  w_idx;
    logic              w_access;
    logic              w_done;

    assign w_idx    = i_req.paddr[IDX_W+1:2];
    assign w_access = i_sel && i_req.penable;

    // Last ACCESS cycle once the wait states have run out
    assign w_done = w_access && (r_wait_cnt == CNT_W'(WAIT_CYCLES));

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            r_wait_cnt <= '0;
        end else if (w_done) begin
            r_wait_cnt <= '0;
        end else if (w_access) begin
            r_wait_cnt <= r_wait_cnt + 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (w_done && i_req.pwrite) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (i_req.pstrb[b]) begin
                    r_mem[w_idx][8*b +: 8] <= i_req.pwdata[8*b +: 8];
                end
            end
        end
    end

    always_comb begin
        o_ret.prdata  = w_done ? r_mem[w_idx] : '0;
        o_ret.pready  = w_done;
        o_ret.pslverr = 1'b0;
    end

    // Every access counts its wait states from zero
    a_wait_len: assert property (@(posedge aclk) disable iff (!aresetn)
        $rose(w_access) |-> (r_wait_cnt == '0));

endmodule

`default_nettype wire

//--- verilog/skid_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module skid_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  wire logic     aclk,
    input  wire logic     aresetn,
    input  wire logic     i_wr_valid,
    output logic          o_wr_ready,
    input  wire payload_t i_wr_data,
    output logic          o_rd_valid,
    input  wire logic     i_rd_ready,
    output payload_t      o_rd_data
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         r_mem [DEPTH];
    logic [PTR_W-1:0] r_wr_ptr;
    logic [PTR_W-1:0] r_rd_ptr;
    logic [CNT_W-1:0] r_count;
    logic             w_wr_en;
    logic             w_rd_en;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign o_wr_ready = (r_count != CNT_W'(DEPTH));
    assign o_rd_valid = (r_count != '0);
    assign o_rd_data  = r_mem[r_rd_ptr];

    assign w_wr_en = i_wr_valid && o_wr_ready;
    assign w_rd_en = i_rd_ready && o_rd_valid;

    always_ff @(posedge aclk) begin
        if (w_wr_en) begin
            r_mem[r_wr_ptr] <= i_wr_data;
        end
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            r_wr_ptr <= '0;
            r_rd_ptr <= '0;
            r_count  <= '0;
        end else begin
            if (w_wr_en) begin
                r_wr_ptr <= next_ptr(r_wr_ptr);
            end
            if (w_rd_en) begin
                r_rd_ptr <= next_ptr(r_rd_ptr);
            end
            case ({w_wr_en, w_rd_en})
                2'b10:   r_count <= r_count + 1'b1;
                2'b01:   r_count <= r_count - 1'b1;
                default: r_count <= r_count;
            endcase
        end
    end

    // A full buffer has its write pointer wrapped round onto the head
    a_no_wr_full: assert property (@(posedge aclk) disable iff (!aresetn)
        (r_count == CNT_W'(DEPTH)) |-> (r_wr_ptr == r_rd_ptr));

    // An empty buffer has read everything that was written
    a_no_rd_empty: assert property (@(posedge aclk) disable iff (!aresetn)
        (r_count == '0) |-> (r_wr_ptr == r_rd_ptr));

endmodule

`default_nettype wire
